// File: verif/ctrl_cases.txt
# id instr status rnd ref stall flush ctrl bv cond (id and flags decimal, others hex)
# ctrl = {sel_pc[1:0], load_pc, sel_branch_imm, sel_a, sel_b, alu_op[2:0],
#         sel_pre_indexed, en_status, sel_load_lr, w_en1, mem_w_en}
# rnd 1 takes status from the random generator, ctrl/bv/cond are expected values
0  E0003000 00000000 1 0 0 0 0B02 0 E
1  E0302000 00000000 1 1 0 0 0B2A 1 E
2  E1500005 00000000 1 0 0 0 0928 0 E
3  E2604000 00000000 1 0 0 0 0A42 0 E
4  E6900000 00000000 1 1 0 0 0A6A 1 E
5  E1A00000 00000000 1 0 0 0 09E2 0 E
6  E0C00000 00000000 1 0 0 0 0B02 0 E
7  00200000 00000000 1 1 0 0 0B22 1 0
8  EC0E1004 00000000 1 0 0 0 0902 0 E
9  EE080000 00000000 1 1 0 0 0921 1 E
10 ED060000 00000000 1 0 0 0 0810 0 E
11 E8100000 00000000 1 0 0 0 0938 0 E
12 EF0C0000 00000000 1 1 0 0 0801 1 E
13 EE020000 00000000 1 0 0 0 0931 0 E
14 EC0A0000 00000000 1 0 0 0 0922 0 E
15 EC040000 00000000 1 1 0 0 0910 1 E
16 09000010 40000000 0 0 0 0 3F00 1 0
17 19000010 40000000 0 1 0 0 0F00 1 1
18 29000010 20000000 0 1 0 0 3F00 0 2
19 39000010 20000000 0 0 0 0 0F00 0 3
20 49800010 80000000 0 0 0 0 3F02 1 4
21 59400000 00000000 0 1 0 0 3A00 0 5
22 69800020 00000000 0 1 0 0 0F02 1 6
23 79000010 10000000 0 0 0 0 0F00 0 7
24 89000010 20000000 0 0 0 0 3F00 1 8
25 99000010 20000000 0 1 0 0 0F00 1 9
26 99000010 00000000 0 1 0 0 3F00 0 9
27 A9400000 90000000 0 0 0 0 3A00 1 A
28 B9000010 90000000 0 0 0 0 0F00 0 B
29 C9000010 20000000 0 1 0 0 3F00 0 C
30 D9800010 80000000 0 1 0 0 3F02 0 D
31 D9000010 00000000 0 0 0 0 0F00 0 D
32 E9000010 00000000 1 0 0 0 3F00 1 E
33 E9800010 00000000 1 1 0 0 3F02 0 E
34 F9000010 F0000000 0 1 0 0 0000 1 F
35 F0003000 00000000 1 0 0 0 0000 0 F
36 E0003000 00000000 1 0 0 0 0B02 0 E
37 E1A00000 00000000 1 1 1 0 0B02 0 E
38 EE080000 00000000 1 1 1 0 0B02 0 E
39 E0302000 00000000 1 1 1 1 0000 1 F
40 EC0E0000 00000000 1 0 0 1 0000 0 F
41 E1A00000 00000000 1 0 0 0 09E2 0 E

// File: sim.f
+incdir+design
design/cpu_ctrl_pkg.sv
design/decode_stage.sv
design/cond_check.sv
design/control_decoder.sv
design/cpu_ctrl_top.sv
verif/cpu_ctrl_tb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = cpu_ctrl_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/cpu_ctrl_tb.sv
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module cpu_ctrl_tb;

    localparam int MAX_CASES    = 64;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 20;
    localparam int CTRL_W       = 14;
    localparam int FIELDS_W     = `CPU_OPC_W + `CPU_REG_W + 2 + `CPU_IMM12_W;

    // bubble word as the stage holds it after reset or flush
    localparam logic [`CPU_INSTR_W-1:0] BUBBLE_WORD =
        {`CPU_COND_BUBBLE, {(`CPU_INSTR_W - `CPU_COND_W){1'b0}}};

    logic                     clk;
    logic                     rst;
    logic [`CPU_INSTR_W-1:0]  instr_in;
    logic                     branch_ref;
    logic                     branch_in;
    logic                     sel_stall;
    logic [`CPU_INSTR_W-1:0]  status_reg;

    logic [`CPU_COND_W-1:0]   cond;
    logic [`CPU_OPC_W-1:0]    opcode;
    logic [`CPU_REG_W-1:0]    rd;
    logic [1:0]               shift_op;
    logic [`CPU_IMM12_W-1:0]  imm12;
    logic [`CPU_INSTR_W-1:0]  imm_branch;
    logic [`CPU_INSTR_W-1:0]  instr_output;
    logic                     branch_value;
    logic [1:0]               sel_pc;
    logic                     load_pc;
    logic                     sel_branch_imm;
    logic                     sel_a;
    logic                     sel_b;
    logic [2:0]               alu_op;
    logic                     sel_pre_indexed;
    logic                     en_status;
    logic                     sel_load_lr;
    logic                     w_en1;
    logic                     mem_w_en;

    // case table as read from the data file
    int                       case_id     [MAX_CASES];
    logic [`CPU_INSTR_W-1:0]  case_instr  [MAX_CASES];
    logic [`CPU_INSTR_W-1:0]  case_status [MAX_CASES];
    logic                     case_rnd    [MAX_CASES];
    logic                     case_ref    [MAX_CASES];
    logic                     case_stall  [MAX_CASES];
    logic                     case_flush  [MAX_CASES];
    logic [15:0]              case_ctrl   [MAX_CASES];
    logic                     case_bv     [MAX_CASES];
    logic [`CPU_COND_W-1:0]   case_cond   [MAX_CASES];

    int                       n_cases;
    int                       n_pass;
    int                       n_fail;
    bit                       cases_loaded;
    logic [31:0]              lcg_state;
    // word the decode stage should hold after the next rising edge
    logic [`CPU_INSTR_W-1:0]  stage_word;

    cpu_ctrl_top dut_i (
        .clk             (clk),
        .rst             (rst),
        .instr_in        (instr_in),
        .branch_ref      (branch_ref),
        .branch_in       (branch_in),
        .sel_stall       (sel_stall),
        .status_reg      (status_reg),
        .cond            (cond),
        .opcode          (opcode),
        .rd              (rd),
        .shift_op        (shift_op),
        .imm12           (imm12),
        .imm_branch      (imm_branch),
        .instr_output    (instr_output),
        .branch_value    (branch_value),
        .sel_pc          (sel_pc),
        .load_pc         (load_pc),
        .sel_branch_imm  (sel_branch_imm),
        .sel_a           (sel_a),
        .sel_b           (sel_b),
        .alu_op          (alu_op),
        .sel_pre_indexed (sel_pre_indexed),
        .en_status       (en_status),
        .sel_load_lr     (sel_load_lr),
        .w_en1           (w_en1),
        .mem_w_en        (mem_w_en)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // signed word offset times four
    function automatic logic [31:0] branch_byte_offset(input logic [31:0] word);
        int offset;
        offset = int'(word[`CPU_BOFF_MSB:0]);
        if (word[`CPU_BOFF_MSB]) begin
            offset = offset - (1 << (`CPU_BOFF_MSB + 1));
        end
        return offset * 4;
    endfunction

    task automatic load_cases();
        int          fd;
        string       line;
        int          n;
        int          id;
        logic [31:0] instr;
        logic [31:0] status;
        int          rnd;
        int          ref_bit;
        int          stall;
        int          flush;
        logic [15:0] ctrl;
        int          bv;
        logic [3:0]  cnd;
        fd = $fopen("verif/ctrl_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/ctrl_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %h %h %d %d %d %d %h %d %h", id, instr, status,
                                rnd, ref_bit, stall, flush, ctrl, bv, cnd);
                    if (n == 10 && n_cases < MAX_CASES) begin
                        case_id[n_cases]     = id;
                        case_instr[n_cases]  = instr;
                        case_status[n_cases] = status;
                        case_rnd[n_cases]    = rnd[0];
                        case_ref[n_cases]    = ref_bit[0];
                        case_stall[n_cases]  = stall[0];
                        case_flush[n_cases]  = flush[0];
                        case_ctrl[n_cases]   = ctrl;
                        case_bv[n_cases]     = bv[0];
                        case_cond[n_cases]   = cnd;
                        n_cases++;
                    end else if (n > 0) begin
                        $display("case file line could not be used: %s", line);
                        n_fail++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // inputs for one case, status from the LCG when the case allows any flags
    task automatic drive_case(input int idx);
        instr_in   = case_instr[idx];
        branch_ref = case_ref[idx];
        sel_stall  = case_stall[idx];
        branch_in  = case_flush[idx];
        if (case_rnd[idx]) begin
            lcg_state  = lcg_next(lcg_state);
            status_reg = lcg_state;
        end else begin
            status_reg = case_status[idx];
        end
        // flush beats stall, stall keeps the held word
        if (case_flush[idx]) begin
            stage_word = BUBBLE_WORD;
        end else if (!case_stall[idx]) begin
            stage_word = case_instr[idx];
        end
    endtask

    task automatic check_outputs(input string name, input logic [CTRL_W-1:0] exp_ctrl,
                                 input logic exp_bv, input logic [`CPU_COND_W-1:0] exp_cond,
                                 input logic [`CPU_INSTR_W-1:0] exp_word);
        logic [CTRL_W-1:0]       act_ctrl;
        logic [FIELDS_W-1:0]     act_fields;
        logic [FIELDS_W-1:0]     exp_fields;
        logic [`CPU_INSTR_W-1:0] exp_imm;
        int                      errs;
        errs = 0;
        act_ctrl = {sel_pc, load_pc, sel_branch_imm, sel_a, sel_b, alu_op,
                    sel_pre_indexed, en_status, sel_load_lr, w_en1, mem_w_en};
        act_fields = {opcode, rd, shift_op, imm12};
        exp_fields = {exp_word[`CPU_OPC_MSB:`CPU_OPC_LSB],
                      exp_word[`CPU_RD_MSB:`CPU_RD_LSB],
                      exp_word[`CPU_SHIFT_MSB:`CPU_SHIFT_LSB],
                      exp_word[`CPU_IMM12_LSB +: `CPU_IMM12_W]};
        exp_imm = branch_byte_offset(exp_word);
        assert (act_ctrl === exp_ctrl) else begin
            $display("Fail %s controls expected %h actual %h", name, exp_ctrl, act_ctrl);
            errs++;
        end
        assert (branch_value === exp_bv) else begin
            $display("Fail %s branch_value expected %b actual %b", name, exp_bv, branch_value);
            errs++;
        end
        assert (cond === exp_cond) else begin
            $display("Fail %s cond expected %h actual %h", name, exp_cond, cond);
            errs++;
        end
        assert (instr_output === exp_word) else begin
            $display("Fail %s instr_output expected %h actual %h", name, exp_word, instr_output);
            errs++;
        end
        // opcode, rd, shift_op, imm12 packed together
        assert (act_fields === exp_fields) else begin
            $display("Fail %s fields expected %h actual %h", name, exp_fields, act_fields);
            errs++;
        end
        assert (imm_branch === exp_imm) else begin
            $display("Fail %s imm_branch expected %h actual %h", name, exp_imm, imm_branch);
            errs++;
        end
        if (errs == 0) begin
            n_pass++;
            $display("%s passed", name);
        end else begin
            n_fail++;
            $display("%s failed with %0d mismatches", name, errs);
        end
    endtask

    initial begin
        int i;
        clk          = 1'b0;
        rst          = 1'b1;
        instr_in     = BUBBLE_WORD;
        branch_ref   = 1'b0;
        branch_in    = 1'b0;
        // stall keeps the bubble in place right after reset
        sel_stall    = 1'b1;
        status_reg   = '0;
        lcg_state    = 32'd68;
        stage_word   = BUBBLE_WORD;
        n_cases      = 0;
        n_pass       = 0;
        n_fail       = 0;
        cases_loaded = 1'b0;
        load_cases();
        if (n_cases == 0) begin
            $display("no usable case in verif/ctrl_cases.txt");
            $display("TEST FAIL");
        end else begin
            cases_loaded = 1'b1;
            repeat (RESET_CYCLES) @(negedge clk);
            rst = 1'b0;
            @(negedge clk);
            check_outputs("reset", {CTRL_W{1'b0}}, 1'b0, `CPU_COND_BUBBLE, stage_word);
            drive_case(0);
            for (i = 0; i < n_cases; i++) begin
                // one rising edge from drive to check
                @(negedge clk);
                check_outputs($sformatf("case_%0d", case_id[i]),
                              case_ctrl[i][CTRL_W-1:0], case_bv[i], case_cond[i],
                              stage_word);
                if (i + 1 < n_cases) begin
                    drive_case(i + 1);
                end
            end
            $display("%0d tests run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
            if (n_fail == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
        end
        $finish;
    end

    // watchdog sized from the case count
    initial begin
        wait (cases_loaded);
        #((n_cases + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("run timed out after %0d cases worth of cycles", n_cases);
        $display("TEST FAIL");
        $finish;
    end

endmodule : cpu_ctrl_tb

// File: design/cpu_ctrl_top.sv
`timescale 1ns/1ps

module cpu_ctrl_top (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_ctrl_pkg::instr_t   instr_in,
    input  logic                   branch_ref,
    input  logic                   branch_in,
    input  logic                   sel_stall,
    input  cpu_ctrl_pkg::instr_t   status_reg,
    output cpu_ctrl_pkg::cond_t    cond,
    output cpu_ctrl_pkg::opcode_t  opcode,
    output cpu_ctrl_pkg::reg_idx_t rd,
    output logic [1:0]             shift_op,
    output cpu_ctrl_pkg::imm12_t   imm12,
    output cpu_ctrl_pkg::instr_t   imm_branch,
    output cpu_ctrl_pkg::instr_t   instr_output,
    output logic                   branch_value,
    output cpu_ctrl_pkg::pc_sel_t  sel_pc,
    output logic                   load_pc,
    output logic                   sel_branch_imm,
    output logic                   sel_a,
    output logic                   sel_b,
    output cpu_ctrl_pkg::alu_op_t  alu_op,
    output logic                   sel_pre_indexed,
    output logic                   en_status,
    output logic                   sel_load_lr,
    output logic                   w_en1,
    output logic                   mem_w_en
);

    // decode stage and controller for the datapath
    control_decoder control_decoder_i (
        .clk             (clk),
        .rst             (rst),
        .instr_in        (instr_in),
        .branch_ref      (branch_ref),
        .branch_in       (branch_in),
        .sel_stall       (sel_stall),
        .status_reg      (status_reg),
        .cond            (cond),
        .opcode          (opcode),
        .rd              (rd),
        .shift_op        (shift_op),
        .imm12           (imm12),
        .imm_branch      (imm_branch),
        .instr_output    (instr_output),
        .branch_value    (branch_value),
        .sel_pc          (sel_pc),
        .load_pc         (load_pc),
        .sel_branch_imm  (sel_branch_imm),
        .sel_a           (sel_a),
        .sel_b           (sel_b),
        .alu_op          (alu_op),
        .sel_pre_indexed (sel_pre_indexed),
        .en_status       (en_status),
        .sel_load_lr     (sel_load_lr),
        .w_en1           (w_en1),
        .mem_w_en        (mem_w_en)
    );

endmodule : cpu_ctrl_top

// File: design/control_decoder.sv
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module control_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_ctrl_pkg::instr_t   instr_in,
    input  logic                   branch_ref,
    input  logic                   branch_in,
    input  logic                   sel_stall,
    input  cpu_ctrl_pkg::instr_t   status_reg,
    output cpu_ctrl_pkg::cond_t    cond,
    output cpu_ctrl_pkg::opcode_t  opcode,
    output cpu_ctrl_pkg::reg_idx_t rd,
    output logic [1:0]             shift_op,
    output cpu_ctrl_pkg::imm12_t   imm12,
    output cpu_ctrl_pkg::instr_t   imm_branch,
    output cpu_ctrl_pkg::instr_t   instr_output,
    output logic                   branch_value,
    output cpu_ctrl_pkg::pc_sel_t  sel_pc,
    output logic                   load_pc,
    output logic                   sel_branch_imm,
    output logic                   sel_a,
    output logic                   sel_b,
    output cpu_ctrl_pkg::alu_op_t  alu_op,
    output logic                   sel_pre_indexed,
    output logic                   en_status,
    output logic                   sel_load_lr,
    output logic                   w_en1,
    output logic                   mem_w_en
);

    // compare writes flags only
    localparam logic [3:0] OPC_CMP = 4'b1010;

    logic en_status_dec;
    logic p;
    logic u;
    logic w;
    logic branch_ref_q;
    logic cond_pass;
    logic is_bubble;
    logic is_normal;
    logic is_mem;
    logic is_branch;

    decode_stage decode_stage_i (
        .clk          (clk),
        .rst          (rst),
        .instr_in     (instr_in),
        .branch_ref   (branch_ref),
        .branch_in    (branch_in),
        .sel_stall    (sel_stall),
        .cond         (cond),
        .opcode       (opcode),
        .en_status    (en_status_dec),
        .rd           (rd),
        .shift_op     (shift_op),
        .imm12        (imm12),
        .imm_branch   (imm_branch),
        .p            (p),
        .u            (u),
        .w            (w),
        .branch_ref_q (branch_ref_q),
        .instr_output (instr_output)
    );

    cond_check cond_check_i (
        .cond       (cond),
        .status_reg (status_reg),
        .cond_pass  (cond_pass)
    );

    // instruction class from the registered opcode
    assign is_bubble = (cond == `CPU_COND_BUBBLE);
    assign is_normal = !opcode[6] && (opcode[5:4] != 2'b10);
    assign is_mem    = (opcode[6:5] == 2'b11) || (opcode[6:3] == 4'b1000);
    assign is_branch = (opcode[6:3] == 4'b1001);

    always_comb begin
        sel_pc          = cpu_ctrl_pkg::PC_SEQ;
        load_pc         = 1'b0;
        sel_branch_imm  = 1'b0;
        sel_a           = 1'b0;
        sel_b           = 1'b0;
        alu_op          = cpu_ctrl_pkg::ALU_ADD;
        sel_pre_indexed = 1'b0;
        en_status       = 1'b0;
        sel_load_lr     = 1'b0;
        w_en1           = 1'b0;
        mem_w_en        = 1'b0;
        branch_value    = branch_ref_q;

        if (!is_bubble && is_normal) begin
            load_pc   = 1'b1;
            sel_a     = !opcode[3];
            sel_b     = !opcode[4];
            en_status = en_status_dec;
            w_en1     = (opcode[3:0] != OPC_CMP);
            case (opcode[2:0])
                3'b001:  alu_op = cpu_ctrl_pkg::ALU_SUB;
                3'b010:  alu_op = cpu_ctrl_pkg::ALU_SUB;
                3'b011:  alu_op = cpu_ctrl_pkg::ALU_AND;
                3'b100:  alu_op = cpu_ctrl_pkg::ALU_ORR;
                3'b101:  alu_op = cpu_ctrl_pkg::ALU_XOR;
                default: alu_op = cpu_ctrl_pkg::ALU_ADD;
            endcase
        end else if (!is_bubble && is_mem) begin
            // address always based on rn
            load_pc         = 1'b1;
            sel_b           = !opcode[3];
            sel_pre_indexed = !p;
            alu_op          = u ? cpu_ctrl_pkg::ALU_ADD : cpu_ctrl_pkg::ALU_SUB;
            en_status       = en_status_dec;
            // writeback of base only when pre-indexed
            w_en1           = p && w;
            mem_w_en        = opcode[4];
        end else if (!is_bubble && is_branch) begin
            load_pc = 1'b1;
            sel_a   = 1'b1;
            if (!opcode[1]) begin
                sel_b          = 1'b1;
                sel_branch_imm = 1'b1;
            end
            // link variant
            if (opcode[2]) begin
                w_en1 = 1'b1;
            end
            if (cond_pass) begin
                sel_pc       = cpu_ctrl_pkg::PC_BRANCH;
                branch_value = !branch_ref_q;
            end
        end
    end

    a_no_store_on_branch : assert property (
        @(posedge clk) disable iff (rst)
        !(mem_w_en && (sel_pc == cpu_ctrl_pkg::PC_BRANCH))
    ) else $error("control_decoder: store issued with branch PC select");

    // a bubble in the stage leaves the datapath idle
    a_bubble_idle : assert property (
        @(posedge clk) disable iff (rst)
        (cond == `CPU_COND_BUBBLE) |->
            (sel_pc == cpu_ctrl_pkg::PC_SEQ) && !load_pc && !sel_branch_imm
            && !sel_a && !sel_b && (alu_op == cpu_ctrl_pkg::ALU_ADD)
            && !sel_pre_indexed && !en_status && !sel_load_lr && !w_en1
            && !mem_w_en && (branch_value == branch_ref_q)
    ) else $error("control_decoder: control active during bubble");

endmodule : control_decoder

// File: design/cond_check.sv
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module cond_check (
    input  cpu_ctrl_pkg::cond_t  cond,
    input  cpu_ctrl_pkg::instr_t status_reg,
    output logic                 cond_pass
);

    logic n_flag;
    logic z_flag;
    logic c_flag;
    logic v_flag;

    assign n_flag = status_reg[`CPU_FLAG_N];
    assign z_flag = status_reg[`CPU_FLAG_Z];
    assign c_flag = status_reg[`CPU_FLAG_C];
    assign v_flag = status_reg[`CPU_FLAG_V];

    always_comb begin
        case (cond)
            // EQ, NE
            4'b0000: cond_pass = z_flag;
            4'b0001: cond_pass = !z_flag;
            // CS, CC
            4'b0010: cond_pass = c_flag;
            4'b0011: cond_pass = !c_flag;
            // MI, PL
            4'b0100: cond_pass = n_flag;
            4'b0101: cond_pass = !n_flag;
            // VS, VC
            4'b0110: cond_pass = v_flag;
            4'b0111: cond_pass = !v_flag;
            // HI, LS (unsigned compare)
            4'b1000: cond_pass = c_flag && !z_flag;
            4'b1001: cond_pass = !c_flag || z_flag;
            // GE, LT (signed)
            4'b1010: cond_pass = (n_flag == v_flag);
            4'b1011: cond_pass = (n_flag != v_flag);
            // GT, LE
            4'b1100: cond_pass = !z_flag && (n_flag == v_flag);
            4'b1101: cond_pass = z_flag || (n_flag != v_flag);
            // AL
            4'b1110: cond_pass = 1'b1;
            // bubble never executes
            default: cond_pass = 1'b0;
        endcase
    end

endmodule : cond_check

// File: design/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_ctrl_pkg::instr_t   instr_in,
    input  logic                   branch_ref,
    input  logic                   branch_in,
    input  logic                   sel_stall,
    output cpu_ctrl_pkg::cond_t    cond,
    output cpu_ctrl_pkg::opcode_t  opcode,
    output logic                   en_status,
    output cpu_ctrl_pkg::reg_idx_t rd,
    output logic [1:0]             shift_op,
    output cpu_ctrl_pkg::imm12_t   imm12,
    output cpu_ctrl_pkg::instr_t   imm_branch,
    output logic                   p,
    output logic                   u,
    output logic                   w,
    output logic                   branch_ref_q,
    output cpu_ctrl_pkg::instr_t   instr_output
);

    // bubble: never-pass condition, everything else zero
    localparam cpu_ctrl_pkg::instr_t BUBBLE_WORD =
        {`CPU_COND_BUBBLE, {(`CPU_INSTR_W - `CPU_COND_W){1'b0}}};

    cpu_ctrl_pkg::instr_t instr_q;

    // stage register, flush wins over stall
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_q      <= BUBBLE_WORD;
            branch_ref_q <= 1'b0;
        end else if (branch_in) begin
            instr_q      <= BUBBLE_WORD;
            // taken branch hands back the new parity
            branch_ref_q <= branch_ref;
        end else if (!sel_stall) begin
            instr_q      <= instr_in;
            branch_ref_q <= branch_ref;
        end
    end

    // field split
    assign cond      = instr_q[`CPU_COND_MSB:`CPU_COND_LSB];
    assign opcode    = instr_q[`CPU_OPC_MSB:`CPU_OPC_LSB];
    assign en_status = instr_q[`CPU_EN_STATUS_BIT];
    assign p         = instr_q[`CPU_P_BIT];
    assign u         = instr_q[`CPU_U_BIT];
    assign w         = instr_q[`CPU_W_BIT];
    assign rd        = instr_q[`CPU_RD_MSB:`CPU_RD_LSB];
    assign shift_op  = instr_q[`CPU_SHIFT_MSB:`CPU_SHIFT_LSB];
    assign imm12     = instr_q[`CPU_IMM12_LSB +: `CPU_IMM12_W];

    // word offset, sign extended then scaled to bytes
    assign imm_branch = {
        {(`CPU_INSTR_W - `CPU_BOFF_W - 2){instr_q[`CPU_BOFF_MSB]}},
        instr_q[`CPU_BOFF_MSB:0],
        2'b00
    };

    assign instr_output = instr_q;

    // a flush must show up as a bubble on the next edge, stall or not
    a_flush_bubble : assert property (
        @(posedge clk) disable iff (rst)
        branch_in |=> (cond == `CPU_COND_BUBBLE)
    ) else $error("decode_stage: flush did not load a bubble");

endmodule : decode_stage

// File: design/cpu_ctrl_pkg.sv
`include "cpu_ctrl_config.svh"

package cpu_ctrl_pkg;

    // full instruction or status word
    typedef logic [`CPU_INSTR_W-1:0] instr_t;

    // decoded instruction fields
    typedef logic [`CPU_COND_W-1:0]  cond_t;
    typedef logic [`CPU_OPC_W-1:0]   opcode_t;
    typedef logic [`CPU_REG_W-1:0]   reg_idx_t;
    typedef logic [`CPU_IMM12_W-1:0] imm12_t;

    // ALU operation select
    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 3'b000;
    localparam alu_op_t ALU_SUB = 3'b001;
    localparam alu_op_t ALU_AND = 3'b010;
    localparam alu_op_t ALU_ORR = 3'b011;
    localparam alu_op_t ALU_XOR = 3'b111;

    // next PC source
    typedef logic [1:0] pc_sel_t;

    // sequential fetch
    localparam pc_sel_t PC_SEQ    = 2'b00;
    // branch target from the ALU
    localparam pc_sel_t PC_BRANCH = 2'b11;

endpackage : cpu_ctrl_pkg

// File: design/cpu_ctrl_config.svh
`ifndef CPU_CTRL_CONFIG_SVH
`define CPU_CTRL_CONFIG_SVH

// word and field widths
`define CPU_INSTR_W        32
`define CPU_COND_W         4
`define CPU_OPC_W          7
`define CPU_REG_W          4
`define CPU_IMM12_W        12
`define CPU_BOFF_W         20

// never-pass condition, doubles as the bubble marker
`define CPU_COND_BUBBLE    4'b1111

// field positions inside the instruction word
`define CPU_COND_MSB       31
`define CPU_COND_LSB       28
`define CPU_OPC_MSB        27
`define CPU_OPC_LSB        21
`define CPU_EN_STATUS_BIT  20
`define CPU_P_BIT          19
`define CPU_U_BIT          18
`define CPU_W_BIT          17
`define CPU_RD_MSB         15
`define CPU_RD_LSB         12
`define CPU_SHIFT_MSB      11
`define CPU_SHIFT_LSB      10
`define CPU_IMM12_LSB      0
`define CPU_BOFF_MSB       19

// status register flag positions
`define CPU_FLAG_N         31
`define CPU_FLAG_Z         30
`define CPU_FLAG_C         29
`define CPU_FLAG_V         28

`endif
